// ==== hw/ascon_pkg.sv ====
// ##############################
// Ascon control definitions
// ##############################

package ascon_pkg;

  // Round counter
  localparam int ROUND_W = 4;

  typedef logic [ROUND_W-1:0] round_t;

  // First round of a 12-round permutation
  localparam round_t ROUND_FIRST_A = 4'd0;
  // First round of a 6-round permutation
  localparam round_t ROUND_FIRST_B = 4'd6;
  // Both permutations end here
  localparam round_t ROUND_LAST = 4'd11;

  // Text block counter
  localparam int BLOCK_W = 2;

  // Plaintext blocks that run 6 rounds
  localparam logic [BLOCK_W-1:0] NUM_FULL_TEXT = 2'd3;

  // Sequencer phases
  typedef enum logic [3:0] {
    ph_idle         = 4'd0,
    ph_conf_init    = 4'd1,
    ph_init_rounds  = 4'd2,
    ph_wait_ad      = 4'd3,
    ph_ad_rounds    = 4'd4,
    ph_wait_text    = 4'd5,
    ph_text_rounds  = 4'd6,
    // Last block has no permutation of its own
    ph_wait_last    = 4'd7,
    ph_last_text    = 4'd8,
    ph_final_rounds = 4'd9,
    ph_done         = 4'd10
  } phase_t;

endpackage

// ==== hw/round_counter.sv ====
// ##############################
// Round counter
// ##############################

`timescale 1ns/10ps

module round_counter (
  input  logic              clock_i,
  input  logic              resetb_i,
  input  ascon_pkg::phase_t phase_i,
  output ascon_pkg::round_t round_o,
  output logic              round_last_o
);

  ascon_pkg::round_t round_q;

  always_ff @(posedge clock_i or negedge resetb_i)
  begin
    if (!resetb_i)
    begin
      round_q <= '0;
    end
    else
    begin
      case (phase_i)
        ascon_pkg::ph_conf_init,
        ascon_pkg::ph_last_text:
        begin
          round_q <= ascon_pkg::ROUND_FIRST_A;
        end
        // Preset for the 6-round permutation that follows
        ascon_pkg::ph_wait_ad,
        ascon_pkg::ph_wait_text,
        ascon_pkg::ph_wait_last:
        begin
          round_q <= ascon_pkg::ROUND_FIRST_B;
        end
        ascon_pkg::ph_init_rounds,
        ascon_pkg::ph_ad_rounds,
        ascon_pkg::ph_text_rounds,
        ascon_pkg::ph_final_rounds:
        begin
          round_q <= round_q + 1'b1;
        end
        default:
        begin
          round_q <= round_q;
        end
      endcase
    end
  end

  assign round_o      = round_q;
  assign round_last_o = (round_q == ascon_pkg::ROUND_LAST);

  // Round stays in range during a permutation
  a_round_in_range: assert property (
    @(posedge clock_i) disable iff (!resetb_i)
    (phase_i inside {ascon_pkg::ph_init_rounds, ascon_pkg::ph_ad_rounds,
                     ascon_pkg::ph_text_rounds, ascon_pkg::ph_final_rounds})
    |-> (round_q <= ascon_pkg::ROUND_LAST)
  );

endmodule

// ==== hw/phase_fsm.sv ====
// ##############################
// Phase sequencer FSM
// ##############################

`timescale 1ns/10ps

module phase_fsm (
  input  logic              clock_i,
  input  logic              resetb_i,
  input  logic              start_i,
  input  logic              data_valid_i,
  input  logic              round_last_i,
  output ascon_pkg::phase_t phase_o
);

  ascon_pkg::phase_t phase_q;
  ascon_pkg::phase_t phase_d;

  logic [ascon_pkg::BLOCK_W-1:0] text_cnt_q;
  logic                          text_full;

  // Current block is the last one that runs 6 rounds
  assign text_full = (text_cnt_q == ascon_pkg::NUM_FULL_TEXT - 1'b1);

  always_ff @(posedge clock_i or negedge resetb_i)
  begin
    if (!resetb_i)
    begin
      phase_q <= ascon_pkg::ph_idle;
    end
    else
    begin
      phase_q <= phase_d;
    end
  end

  // Completed full text blocks
  always_ff @(posedge clock_i or negedge resetb_i)
  begin
    if (!resetb_i)
    begin
      text_cnt_q <= '0;
    end
    else if (phase_q == ascon_pkg::ph_wait_ad)
    begin
      text_cnt_q <= '0;
    end
    else if (phase_q == ascon_pkg::ph_text_rounds && round_last_i)
    begin
      text_cnt_q <= text_cnt_q + 1'b1;
    end
  end

  always_comb
  begin
    phase_d = phase_q;
    case (phase_q)
      ascon_pkg::ph_idle:
      begin
        if (start_i)
        begin
          phase_d = ascon_pkg::ph_conf_init;
        end
      end
      ascon_pkg::ph_conf_init:
      begin
        phase_d = ascon_pkg::ph_init_rounds;
      end
      ascon_pkg::ph_init_rounds:
      begin
        if (round_last_i)
        begin
          phase_d = ascon_pkg::ph_wait_ad;
        end
      end
      ascon_pkg::ph_wait_ad:
      begin
        if (data_valid_i)
        begin
          phase_d = ascon_pkg::ph_ad_rounds;
        end
      end
      ascon_pkg::ph_ad_rounds:
      begin
        if (round_last_i)
        begin
          phase_d = ascon_pkg::ph_wait_text;
        end
      end
      ascon_pkg::ph_wait_text:
      begin
        if (data_valid_i)
        begin
          phase_d = ascon_pkg::ph_text_rounds;
        end
      end
      ascon_pkg::ph_text_rounds:
      begin
        if (round_last_i)
        begin
          phase_d = text_full ? ascon_pkg::ph_wait_last : ascon_pkg::ph_wait_text;
        end
      end
      ascon_pkg::ph_wait_last:
      begin
        if (data_valid_i)
        begin
          phase_d = ascon_pkg::ph_last_text;
        end
      end
      ascon_pkg::ph_last_text:
      begin
        phase_d = ascon_pkg::ph_final_rounds;
      end
      ascon_pkg::ph_final_rounds:
      begin
        if (round_last_i)
        begin
          phase_d = ascon_pkg::ph_done;
        end
      end
      // Held until reset
      ascon_pkg::ph_done:
      begin
        phase_d = ascon_pkg::ph_done;
      end
      default:
      begin
        phase_d = ascon_pkg::ph_idle;
      end
    endcase
  end

  assign phase_o = phase_q;

  a_done_sticky: assert property (
    @(posedge clock_i) disable iff (!resetb_i)
    (phase_q == ascon_pkg::ph_done) |=> (phase_q == ascon_pkg::ph_done)
  );

  // Counter only advances in a text permutation
  a_block_cnt_range: assert property (
    @(posedge clock_i) disable iff (!resetb_i)
    (phase_q == ascon_pkg::ph_text_rounds) |-> (text_cnt_q < ascon_pkg::NUM_FULL_TEXT)
  );

endmodule

// ==== hw/strobe_decode.sv ====
// ##############################
// Datapath strobe decoder
// ##############################

`timescale 1ns/10ps

module strobe_decode (
  input  ascon_pkg::phase_t phase_i,
  input  ascon_pkg::round_t round_i,
  input  logic              round_last_i,
  output logic              en_state_o,
  output logic              cipher_valid_o,
  output logic              end_o,
  output logic              input_mode_o,
  output logic              bypass_xor_begin_o,
  output logic              mode_data_xor_begin_o,
  output logic              bypass_xor_end_o,
  output logic              key_xor_end_o
);

  logic first_a;
  logic first_b;

  assign first_a = (round_i == ascon_pkg::ROUND_FIRST_A);
  assign first_b = (round_i == ascon_pkg::ROUND_FIRST_B);

  always_comb
  begin
    // Inactive values, XORs bypassed
    en_state_o            = 1'b0;
    cipher_valid_o        = 1'b0;
    end_o                 = 1'b0;
    input_mode_o          = 1'b1;
    bypass_xor_begin_o    = 1'b1;
    mode_data_xor_begin_o = 1'b0;
    bypass_xor_end_o      = 1'b1;
    key_xor_end_o         = 1'b0;
    case (phase_i)
      ascon_pkg::ph_idle,
      ascon_pkg::ph_conf_init:
      begin
        input_mode_o = 1'b0;
      end
      ascon_pkg::ph_init_rounds:
      begin
        en_state_o       = 1'b1;
        bypass_xor_end_o = !round_last_i;
        key_xor_end_o    = round_last_i;
      end
      ascon_pkg::ph_ad_rounds:
      begin
        en_state_o            = 1'b1;
        bypass_xor_begin_o    = !first_b;
        mode_data_xor_begin_o = first_b;
        bypass_xor_end_o      = !round_last_i;
      end
      ascon_pkg::ph_text_rounds:
      begin
        en_state_o            = 1'b1;
        cipher_valid_o        = first_b;
        bypass_xor_begin_o    = !first_b;
        mode_data_xor_begin_o = first_b;
      end
      // Last block is absorbed without a permutation
      ascon_pkg::ph_last_text:
      begin
        cipher_valid_o        = 1'b1;
        bypass_xor_begin_o    = 1'b0;
        mode_data_xor_begin_o = 1'b1;
      end
      ascon_pkg::ph_final_rounds:
      begin
        // Key mode on the begin XOR
        en_state_o         = 1'b1;
        bypass_xor_begin_o = !first_a;
        bypass_xor_end_o   = !round_last_i;
        key_xor_end_o      = round_last_i;
      end
      ascon_pkg::ph_done:
      begin
        end_o = 1'b1;
      end
      default:
      begin
        input_mode_o = 1'b1;
      end
    endcase
  end

endmodule

// ==== hw/ascon_ctrl_top.sv ====
// ##############################
// Ascon control top
// ##############################

`timescale 1ns/10ps

module ascon_ctrl_top (
  input  logic              clock_i,
  input  logic              resetb_i,
  input  logic              start_i,
  input  logic              data_valid_i,
  output ascon_pkg::round_t round_o,
  output logic              en_state_o,
  output logic              cipher_valid_o,
  output logic              end_o,
  output logic              input_mode_o,
  output logic              bypass_xor_begin_o,
  output logic              mode_data_xor_begin_o,
  output logic              bypass_xor_end_o,
  output logic              key_xor_end_o
);

  ascon_pkg::phase_t phase;
  ascon_pkg::round_t round;
  logic              round_last;

  round_counter u_round_counter (
    .clock_i      (clock_i),
    .resetb_i     (resetb_i),
    .phase_i      (phase),
    .round_o      (round),
    .round_last_o (round_last)
  );

  phase_fsm u_phase_fsm (
    .clock_i      (clock_i),
    .resetb_i     (resetb_i),
    .start_i      (start_i),
    .data_valid_i (data_valid_i),
    .round_last_i (round_last),
    .phase_o      (phase)
  );

  strobe_decode u_strobe_decode (
    .phase_i               (phase),
    .round_i               (round),
    .round_last_i          (round_last),
    .en_state_o            (en_state_o),
    .cipher_valid_o        (cipher_valid_o),
    .end_o                 (end_o),
    .input_mode_o          (input_mode_o),
    .bypass_xor_begin_o    (bypass_xor_begin_o),
    .mode_data_xor_begin_o (mode_data_xor_begin_o),
    .bypass_xor_end_o      (bypass_xor_end_o),
    .key_xor_end_o         (key_xor_end_o)
  );

  assign round_o = round;

endmodule

// ==== testbench/tb_ascon_ctrl_util.svh ====
// ##############################
// Testbench helpers
// ##############################

`ifndef TB_ASCON_CTRL_UTIL_SVH
`define TB_ASCON_CTRL_UTIL_SVH

// Galois LFSR, x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] state);
  logic [31:0] nxt;
  nxt = state >> 1;
  if (state[0])
    nxt = nxt ^ 32'h8020_0003;
  return nxt;
endfunction

task automatic check_value(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
  if (expected !== actual)
  begin
    $display("ERR %s expected %0h actual %0h", name, expected, actual);
    $display("Test failures found");
    $fatal(1);
  end
endtask

`endif

// ==== testbench/tb_ascon_ctrl.sv ====
// ##############################
// Ascon control testbench
// ##############################

`timescale 1ns/10ps

module tb_ascon_ctrl;

  localparam int NUM_ROWS = 5;
  localparam int NUM_GAPS = 5;
  // Gap drawn from the LFSR
  localparam int GAP_RANDOM = 255;

  logic       clock_i;
  logic       resetb_i;
  logic       start_i;
  logic       data_valid_i;
  logic [3:0] round_o;
  logic       en_state_o;
  logic       cipher_valid_o;
  logic       end_o;
  logic       input_mode_o;
  logic       bypass_xor_begin_o;
  logic       mode_data_xor_begin_o;
  logic       bypass_xor_end_o;
  logic       key_xor_end_o;

  int          cycle_cnt = 0;
  int          cycle_limit;
  logic [31:0] lfsr_state;

  string row_name  [NUM_ROWS] = '{"zero_gaps", "fixed_gaps", "noisy_valid",
                                  "lfsr_gaps", "lfsr_mixed"};
  int    row_delay [NUM_ROWS] = '{0, 2, 1, 3, 0};
  // Idle cycles ahead of the AD, text and last data_valid_i pulses
  int    row_gap   [NUM_ROWS][NUM_GAPS] = '{'{0, 0, 0, 0, 0}, '{1, 3, 0, 2, 5},
                                           '{0, 2, 1, 0, 3}, '{255, 255, 255, 255, 255},
                                           '{255, 0, 255, 4, 255}};
  // Extra data_valid_i pulses in every rounds cycle
  bit    row_noise [NUM_ROWS] = '{0, 0, 1, 1, 0};

  int gaps [NUM_ROWS][NUM_GAPS];
  // Cycle of each accepted data_valid_i, counted from the start cycle
  int acc [NUM_GAPS];
  int fin_c;
  int done_c;

  `include "tb_ascon_ctrl_util.svh"

  ascon_ctrl_top dut (.*);

  initial
  begin
    clock_i = 1'b0;
    forever #5 clock_i = ~clock_i;
  end

  always @(posedge clock_i)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_limit > 0 && cycle_cnt > cycle_limit)
    begin
      $display("Timeout: the run went past %0d clock cycles", cycle_limit);
      $display("Test failures found");
      $fatal(1);
    end
  end

  function automatic logic rounds_cycle(input int c);
    logic hit;
    hit = (c >= 2 && c <= 13) || (c >= fin_c && c < fin_c + 12);
    for (int k = 0; k < 4; k++)
    begin
      if (c > acc[k] && c <= acc[k] + 6)
        hit = 1'b1;
    end
    return hit;
  endfunction

  function automatic int expect_round(input int c);
    int r;
    r = (c <= 13) ? c - 2 : c - fin_c;
    for (int k = 0; k < 4; k++)
    begin
      if (c > acc[k] && c <= acc[k] + 6)
        r = c - acc[k] + 5;
    end
    return r;
  endfunction

  // en, cipher_valid, end, input_mode, bypass begin, mode data, bypass end, key end
  function automatic logic [7:0] expect_strobes(input int c);
    logic begin_xor;
    logic end_xor;
    logic cv;
    cv = (c == acc[4] + 1);
    begin_xor = cv || (c == fin_c);
    for (int k = 0; k < 4; k++)
    begin
      if (c == acc[k] + 1)
      begin
        begin_xor = 1'b1;
        cv = cv | (k > 0);
      end
    end
    end_xor = (c == 13) || (c == acc[0] + 6) || (c == fin_c + 11);
    return {rounds_cycle(c), cv, c >= done_c, c >= 2, !begin_xor,
            begin_xor && (c != fin_c), !end_xor, (c == 13) || (c == fin_c + 11)};
  endfunction

  function automatic logic [7:0] sample_strobes();
    return {en_state_o, cipher_valid_o, end_o, input_mode_o, bypass_xor_begin_o,
            mode_data_xor_begin_o, bypass_xor_end_o, key_xor_end_o};
  endfunction

  task automatic resolve_gaps();
    logic [2:0] g;
    cycle_limit = 0;
    for (int r = 0; r < NUM_ROWS; r++)
    begin
      for (int k = 0; k < NUM_GAPS; k++)
      begin
        gaps[r][k] = row_gap[r][k];
        if (row_gap[r][k] == GAP_RANDOM)
        begin
          g = 3'd0;
          for (int b = 0; b < 3; b++)
          begin
            g = {g[1:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
          end
          gaps[r][k] = {29'd0, g};
        end
        cycle_limit = cycle_limit + gaps[r][k];
      end
      cycle_limit = cycle_limit + 80;
    end
    cycle_limit = cycle_limit * 2;
  endtask

  task automatic run_row(input int r);
    int t;
    int en_cnt;
    int cv_cnt;
    int key_cnt;
    int bxe_cnt;
    t = 14;
    for (int k = 0; k < NUM_GAPS; k++)
    begin
      acc[k] = t + gaps[r][k];
      t = acc[k] + 7;
    end
    fin_c = acc[4] + 2;
    done_c = acc[4] + 14;
    en_cnt = 0;
    cv_cnt = 0;
    key_cnt = 0;
    bxe_cnt = 0;
    resetb_i = 1'b0;
    start_i = 1'b0;
    data_valid_i = 1'b0;
    repeat (4) @(negedge clock_i);
    resetb_i = 1'b1;
    check_value({row_name[r], " reset strobes"}, 32'h0a, {24'd0, sample_strobes()});
    check_value({row_name[r], " reset round"}, 32'd0, {28'd0, round_o});
    repeat (row_delay[r]) @(negedge clock_i);
    for (int c = 0; c <= done_c + 4; c++)
    begin
      check_value($sformatf("%s cycle %0d strobes", row_name[r], c),
                  {24'd0, expect_strobes(c)}, {24'd0, sample_strobes()});
      if (en_state_o)
      begin
        en_cnt++;
        check_value($sformatf("%s cycle %0d round", row_name[r], c),
                    expect_round(c), {28'd0, round_o});
      end
      if (cipher_valid_o)
        cv_cnt++;
      if (key_xor_end_o)
        key_cnt++;
      if (!bypass_xor_end_o)
        bxe_cnt++;
      // Start and data after done must be ignored
      start_i = (c == 0) || (c > done_c);
      data_valid_i = (c > done_c) || (row_noise[r] && rounds_cycle(c));
      for (int k = 0; k < NUM_GAPS; k++)
      begin
        if (c == acc[k])
          data_valid_i = 1'b1;
      end
      @(negedge clock_i);
    end
    // Two 12-round and four 6-round permutations
    check_value({row_name[r], " en_state count"}, 32'd48, en_cnt);
    check_value({row_name[r], " cipher_valid count"}, 32'd4, cv_cnt);
    check_value({row_name[r], " key_xor_end count"}, 32'd2, key_cnt);
    check_value({row_name[r], " bypass_xor_end low count"}, 32'd3, bxe_cnt);
  endtask

  initial
  begin
    resetb_i = 1'b0;
    start_i = 1'b0;
    data_valid_i = 1'b0;
    lfsr_state = 32'hee8c;
    resolve_gaps();
    for (int r = 0; r < NUM_ROWS; r++)
      run_row(r);
    $display("All tests passed!");
    $finish;
  end

endmodule

// ==== list.f ====
+incdir+testbench
hw/ascon_pkg.sv
hw/round_counter.sv
hw/phase_fsm.sv
hw/strobe_decode.sv
hw/ascon_ctrl_top.sv
testbench/tb_ascon_ctrl.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f list.f --top-module tb_ascon_ctrl -o sim_tb
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "Test failures found" sim.log || ! grep -q "All tests passed!" sim.log; then
  echo "Simulation FAILED"
  exit 1
fi
echo "Simulation PASSED"
